// File: issue_pkg.sv
package issue_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] reg_width_t;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,
        op_mul = 3'd6
    } alu_op_t;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       num1_need;     // clear: num1 is the immediate
        reg_addr_t  num1_addr;
        reg_width_t num1;
        logic       num2_need;
        reg_addr_t  num2_addr;
        reg_width_t num2;
        logic       write_reg_need;
        reg_addr_t  write_reg_addr;
    } iq_element_t;

    typedef struct packed {
        logic       line;          // lane that owns the pending write
        logic [2:0] position;      // one-hot E1/E2/E3, zero once in the regfile
        logic [2:0] accept_mask;   // stages the value may be forwarded from
    } score_board_data_t;

    typedef struct packed {
        logic       valid;
        alu_op_t    alu_op;
        reg_width_t num1;
        reg_width_t num2;
        logic       write_reg_need;
        reg_addr_t  write_reg_addr;
    } fu_require_t;

    localparam logic [2:0] pos_e1 = 3'b100;
    localparam logic [2:0] pos_e2 = 3'b010;
    localparam logic [2:0] pos_e3 = 3'b001;

    localparam logic [2:0] mask_alu = 3'b111;
    localparam logic [2:0] mask_mul = 3'b001; // mul result only leaves E3

endpackage

// File: issue_queue.sv
`timescale 1ns/1ps

module issue_queue
    import issue_pkg::*;
#(
    parameter int iq_depth = 4     // power of two
) (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              in_req,
    output logic              in_ack,
    input  alu_op_t           in_alu_op,
    input  logic              in_num1_need,
    input  reg_addr_t         in_num1_addr,
    input  reg_width_t        in_num1,
    input  logic              in_num2_need,
    input  reg_addr_t         in_num2_addr,
    input  reg_width_t        in_num2,
    input  logic              in_write_reg_need,
    input  reg_addr_t         in_write_reg_addr,

    output iq_element_t [1:0] issue_require,
    output logic [1:0]        iq_size,
    input  logic [1:0]        iq_pop_number
);

    localparam int aw = $clog2(iq_depth);
    localparam int cw = $clog2(iq_depth + 1);

    typedef logic [aw-1:0] ptr_t;
    typedef logic [cw-1:0] cnt_t;
    typedef enum logic {ack_idle, ack_high} ack_state_t;

    iq_element_t mem [iq_depth];
    ptr_t        head;
    ptr_t        tail;
    cnt_t        count;
    ack_state_t  state;
    logic        push;

    // accept only from idle, one entry per req/ack cycle
    assign push   = (state == ack_idle) && in_req && (count < cnt_t'(iq_depth));
    assign in_ack = (state == ack_high);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ack_idle;
        end else begin
            case (state)
                ack_idle: if (push) state <= ack_high;
                ack_high: if (!in_req) state <= ack_idle;
                default:  state <= ack_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + ptr_t'(iq_pop_number); // pop lands on the issue edge
            tail  <= tail + ptr_t'(push);
            count <= count + cnt_t'(push) - cnt_t'(iq_pop_number);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= '{
                alu_op:         in_alu_op,
                num1_need:      in_num1_need,
                num1_addr:      in_num1_addr,
                num1:           in_num1,
                num2_need:      in_num2_need,
                num2_addr:      in_num2_addr,
                num2:           in_num2,
                write_reg_need: in_write_reg_need,
                write_reg_addr: in_write_reg_addr
            };
        end
    end

    // two oldest entries, wrap comes free with a power-of-two depth
    assign issue_require[0] = mem[head];
    assign issue_require[1] = mem[head + ptr_t'(1)];
    assign iq_size          = (count >= cnt_t'(2)) ? 2'd2 : 2'(count);

endmodule

// File: score_board.sv
`timescale 1ns/1ps

module score_board
    import issue_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic [1:0]              write_ena,
    input  reg_addr_t [1:0]         write_addr,
    input  score_board_data_t [1:0] data_in,

    input  reg_addr_t [3:0]         read_addr,
    output score_board_data_t [3:0] data_out
);

    localparam int n_reg = 32;

    score_board_data_t entry [n_reg];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < n_reg; r++) begin
                entry[r] <= '0;
            end
        end else begin
            // pending writes move one stage toward the regfile
            for (int r = 0; r < n_reg; r++) begin
                entry[r].position <= entry[r].position >> 1;
            end
            // lane 1 is younger, so its write goes last
            for (int l = 0; l < 2; l++) begin
                if (write_ena[l] && write_addr[l] != '0) begin
                    entry[write_addr[l]] <= data_in[l];
                end
            end
        end
    end

    // r0 never gets an entry, reads of it always see the regfile
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            data_out[k] = entry[read_addr[k]]; // same-cycle write not visible yet
        end
    end

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile
    import issue_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,

    input  reg_addr_t [3:0]  read_addr,
    output reg_width_t [3:0] read_data,

    input  logic [1:0]       write_ena,
    input  reg_addr_t [1:0]  write_addr,
    input  reg_width_t [1:0] write_data
);

    reg_width_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < 2; l++) begin
                if (write_ena[l] && write_addr[l] != '0) begin
                    regs[write_addr[l]] <= write_data[l]; // lane 1 wins on a clash
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            read_data[k] = (read_addr[k] == '0) ? '0 : regs[read_addr[k]];
        end
    end

endmodule

// File: issue.sv
`timescale 1ns/1ps

module issue
    import issue_pkg::*;
(
    // queue head
    input  iq_element_t [1:0]       issue_require,
    input  logic [1:0]              iq_size,
    output logic [1:0]              iq_pop_number,

    // scoreboard
    output reg_addr_t [3:0]         score_board_read_addr,
    input  score_board_data_t [3:0] score_board_read_data,
    output logic [1:0]              score_board_write_ena,
    output reg_addr_t [1:0]         score_board_write_addr,
    output score_board_data_t [1:0] score_board_write_data,

    // regfile and bypass
    output reg_addr_t [3:0]         regfile_read_addr,
    input  reg_width_t [3:0]        regfile_read_data,
    input  reg_width_t [3:0]        bypass_result,

    output fu_require_t [1:0]       fu_require
);

    // operand j: instruction j/2, num1 when j is even, num2 when odd
    logic [3:0]       opd_need;
    reg_addr_t [3:0]  opd_addr;
    reg_width_t [3:0] opd_imm;
    logic [3:0]       dep_hit;
    logic [3:0]       opd_ready;
    reg_width_t [3:0] opd_val;

    logic             first_ready;
    logic             second_ready;
    logic [1:0]       issue_cnt;

    function automatic logic [2:0] accept_of(alu_op_t op);
        return (op == op_mul) ? mask_mul : mask_alu;
    endfunction

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            opd_need[2*i]   = issue_require[i].num1_need;
            opd_addr[2*i]   = issue_require[i].num1_addr;
            opd_imm[2*i]    = issue_require[i].num1;
            opd_need[2*i+1] = issue_require[i].num2_need;
            opd_addr[2*i+1] = issue_require[i].num2_addr;
            opd_imm[2*i+1]  = issue_require[i].num2;
        end
        // second reads what the head is about to write
        for (int j = 0; j < 4; j++) begin
            dep_hit[j] = (j >= 2) && issue_require[0].write_reg_need
                      && opd_addr[j] != '0
                      && opd_addr[j] == issue_require[0].write_reg_addr;
        end
    end

    assign score_board_read_addr = opd_addr;
    assign regfile_read_addr     = opd_addr;

    always_comb begin
        for (int j = 0; j < 4; j++) begin
            opd_ready[j] = 1'b0;
            opd_val[j]   = '0;
            if (!opd_need[j]) begin
                opd_ready[j] = 1'b1;
                opd_val[j]   = opd_imm[j];
            end else if (!dep_hit[j]) begin
                if (score_board_read_data[j].position == 3'b000) begin
                    opd_ready[j] = 1'b1;                   // settled in the regfile
                    opd_val[j]   = regfile_read_data[j];
                end else if ((score_board_read_data[j].position
                              & score_board_read_data[j].accept_mask) != 3'b000) begin
                    opd_ready[j] = 1'b1;
                    opd_val[j]   = bypass_result[j];
                end
            end
        end
    end

    assign first_ready  = &opd_ready[1:0];
    assign second_ready = &opd_ready[3:2];

    // in-order: the second never goes without the head
    always_comb begin
        if (iq_size == 2'd0 || !first_ready) begin
            issue_cnt = 2'd0;
        end else if (iq_size == 2'd2 && second_ready) begin
            issue_cnt = 2'd2;
        end else begin
            issue_cnt = 2'd1;
        end
    end

    assign iq_pop_number = issue_cnt;

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            fu_require[l]             = '0;
            score_board_write_ena[l]  = 1'b0;
            score_board_write_addr[l] = '0;
            score_board_write_data[l] = '0;
            if (l < int'(issue_cnt)) begin
                fu_require[l].valid          = 1'b1;
                fu_require[l].alu_op         = issue_require[l].alu_op;
                fu_require[l].num1           = opd_val[2*l];
                fu_require[l].num2           = opd_val[2*l+1];
                fu_require[l].write_reg_need = issue_require[l].write_reg_need;
                fu_require[l].write_reg_addr = issue_require[l].write_reg_addr;

                score_board_write_ena[l]  = issue_require[l].write_reg_need;
                score_board_write_addr[l] = issue_require[l].write_reg_addr;
                score_board_write_data[l] = '{
                    line:        1'(l),
                    position:    pos_e1,   // enters E1 on this edge
                    accept_mask: accept_of(issue_require[l].alu_op)
                };
            end
        end
    end

endmodule

// File: exec_pipe.sv
`timescale 1ns/1ps

module exec_pipe
    import issue_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    input  fu_require_t [1:0]       fu_require,
    input  score_board_data_t [3:0] score_board_read_data,
    output reg_width_t [3:0]        bypass_result,

    output logic [1:0]              wb_ena,
    output reg_addr_t [1:0]         wb_addr,
    output reg_width_t [1:0]        wb_data
);

    localparam int n_stage = 3;    // index 0 is E1

    logic [1:0]       st_wr   [n_stage];
    reg_addr_t [1:0]  st_addr [n_stage];
    reg_width_t [1:0] st_res  [n_stage];

    function automatic reg_width_t alu(alu_op_t op, reg_width_t a, reg_width_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            op_mul:  return a * b;      // low word only
            default: return '0;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < n_stage; s++) begin
                st_wr[s] <= '0;
            end
        end else begin
            for (int l = 0; l < 2; l++) begin
                st_wr[0][l] <= fu_require[l].valid & fu_require[l].write_reg_need;
            end
            for (int s = 1; s < n_stage; s++) begin
                st_wr[s] <= st_wr[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < 2; l++) begin
            st_addr[0][l] <= fu_require[l].write_reg_addr;
            st_res[0][l]  <= alu(fu_require[l].alu_op, fu_require[l].num1, fu_require[l].num2);
        end
        for (int s = 1; s < n_stage; s++) begin
            st_addr[s] <= st_addr[s-1];
            st_res[s]  <= st_res[s-1];
        end
    end

    // scoreboard entry names lane and stage of the newest writer
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            case (score_board_read_data[j].position)
                pos_e1:  bypass_result[j] = st_res[0][score_board_read_data[j].line];
                pos_e2:  bypass_result[j] = st_res[1][score_board_read_data[j].line];
                pos_e3:  bypass_result[j] = st_res[2][score_board_read_data[j].line];
                default: bypass_result[j] = '0;
            endcase
        end
    end

    assign wb_ena  = st_wr[n_stage-1];
    assign wb_addr = st_addr[n_stage-1];
    assign wb_data = st_res[n_stage-1];

endmodule

// File: issue_top.sv
`timescale 1ns/1ps

module issue_top
    import issue_pkg::*;
#(
    parameter int iq_depth = 4
) (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             in_req,
    output logic             in_ack,
    input  alu_op_t          in_alu_op,
    input  logic             in_num1_need,
    input  reg_addr_t        in_num1_addr,
    input  reg_width_t       in_num1,
    input  logic             in_num2_need,
    input  reg_addr_t        in_num2_addr,
    input  reg_width_t       in_num2,
    input  logic             in_write_reg_need,
    input  reg_addr_t        in_write_reg_addr,

    output logic [1:0]       wb_ena,
    output reg_addr_t [1:0]  wb_addr,
    output reg_width_t [1:0] wb_data
);

    iq_element_t [1:0]       issue_require;
    logic [1:0]              iq_size;
    logic [1:0]              iq_pop_number;
    reg_addr_t [3:0]         sb_read_addr;
    score_board_data_t [3:0] sb_read_data;
    logic [1:0]              sb_write_ena;
    reg_addr_t [1:0]         sb_write_addr;
    score_board_data_t [1:0] sb_write_data;
    reg_addr_t [3:0]         rf_read_addr;
    reg_width_t [3:0]        rf_read_data;
    reg_width_t [3:0]        bypass_result;
    fu_require_t [1:0]       fu_require;

    issue_queue #(
        .iq_depth(iq_depth)
    ) u_issue_queue (
        .clk               (clk),
        .rst_n             (rst_n),
        .in_req            (in_req),
        .in_ack            (in_ack),
        .in_alu_op         (in_alu_op),
        .in_num1_need      (in_num1_need),
        .in_num1_addr      (in_num1_addr),
        .in_num1           (in_num1),
        .in_num2_need      (in_num2_need),
        .in_num2_addr      (in_num2_addr),
        .in_num2           (in_num2),
        .in_write_reg_need (in_write_reg_need),
        .in_write_reg_addr (in_write_reg_addr),
        .issue_require     (issue_require),
        .iq_size           (iq_size),
        .iq_pop_number     (iq_pop_number)
    );

    issue u_issue (
        .issue_require          (issue_require),
        .iq_size                (iq_size),
        .iq_pop_number          (iq_pop_number),
        .score_board_read_addr  (sb_read_addr),
        .score_board_read_data  (sb_read_data),
        .score_board_write_ena  (sb_write_ena),
        .score_board_write_addr (sb_write_addr),
        .score_board_write_data (sb_write_data),
        .regfile_read_addr      (rf_read_addr),
        .regfile_read_data      (rf_read_data),
        .bypass_result          (bypass_result),
        .fu_require             (fu_require)
    );

    score_board u_score_board (
        .clk        (clk),
        .rst_n      (rst_n),
        .write_ena  (sb_write_ena),
        .write_addr (sb_write_addr),
        .data_in    (sb_write_data),
        .read_addr  (sb_read_addr),
        .data_out   (sb_read_data)
    );

    regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .read_addr  (rf_read_addr),
        .read_data  (rf_read_data),
        .write_ena  (wb_ena),
        .write_addr (wb_addr),
        .write_data (wb_data)
    );

    exec_pipe u_exec_pipe (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .fu_require            (fu_require),
        .score_board_read_data (sb_read_data),
        .bypass_result         (bypass_result),
        .wb_ena                (wb_ena),
        .wb_addr               (wb_addr),
        .wb_data               (wb_data)
    );

endmodule

// File: issue_chk.sv
`timescale 1ns/1ps

module issue_chk
    import issue_pkg::*;
(
    input logic                    clk,
    input logic                    rst_n,
    input logic                    in_req,
    input logic                    in_ack,
    input logic [1:0]              wb_ena,
    input reg_addr_t [3:0]         sb_read_addr,
    input score_board_data_t [3:0] sb_read_data
);

    // ack only answers a raised request
    assert property (@(posedge clk) disable iff (!rst_n) $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without a pending in_req");

    assert property (@(posedge clk) disable iff (!rst_n) $fell(in_ack) |-> !$past(in_req))
        else $error("in_ack fell while in_req was still high");

    assert property (@(posedge clk) !rst_n |-> wb_ena == 2'b00)
        else $error("writeback enabled during reset");

    // a lane writing r0 must never make r0 look pending to a reader
    for (genvar k = 0; k < 4; k++) begin : g_r0
        assert property (@(posedge clk) disable iff (!rst_n)
                         sb_read_addr[k] == '0 |-> sb_read_data[k].position == 3'b000)
            else $error("scoreboard port %0d shows a pending write to r0", k);
    end

endmodule

bind issue_top issue_chk u_issue_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_req       (in_req),
    .in_ack       (in_ack),
    .wb_ena       (wb_ena),
    .sb_read_addr (sb_read_addr),
    .sb_read_data (sb_read_data)
);

// File: tb_issue.sv
`timescale 1ns/1ps

module tb_issue
    import issue_pkg::*;
();

    localparam int depth       = 4;
    localparam int max_prog    = 64;
    localparam int n_tests     = 6;
    localparam int burst_test  = 5;  // no idle gaps, meant to fill the queue
    localparam int ack_limit   = 200;
    localparam int drain_limit = 500;
    localparam int min_mul_gap = 3;  // E1 to E3 before a mul can be forwarded

    logic             clk;
    logic             rst_n;
    logic             in_req;
    logic             in_ack;
    alu_op_t          in_alu_op;
    logic             in_num1_need;
    reg_addr_t        in_num1_addr;
    reg_width_t       in_num1;
    logic             in_num2_need;
    reg_addr_t        in_num2_addr;
    reg_width_t       in_num2;
    logic             in_write_reg_need;
    reg_addr_t        in_write_reg_addr;
    logic [1:0]       wb_ena;
    reg_addr_t [1:0]  wb_addr;
    reg_width_t [1:0] wb_data;

    iq_element_t      prog [max_prog];
    int               prog_test [max_prog];
    int               n_prog;
    int               exp_count [n_tests+1];
    reg_addr_t        exp_addr [$];
    reg_width_t       exp_data [$];
    int               exp_after [$];  // writeback index of the mul it reads, or -1
    int               wb_cycle [$];
    logic [15:0]      lfsr;
    int               errors;
    logic             aborted;
    int               mon_errors = 0;
    int               wb_seen = 0;
    int               cycle_no = 0;

    issue_top #(.iq_depth(depth)) DUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .in_req            (in_req),
        .in_ack            (in_ack),
        .in_alu_op         (in_alu_op),
        .in_num1_need      (in_num1_need),
        .in_num1_addr      (in_num1_addr),
        .in_num1           (in_num1),
        .in_num2_need      (in_num2_need),
        .in_num2_addr      (in_num2_addr),
        .in_num2           (in_num2),
        .in_write_reg_need (in_write_reg_need),
        .in_write_reg_addr (in_write_reg_addr),
        .wb_ena            (wb_ena),
        .wb_addr           (wb_addr),
        .wb_data           (wb_data)
    );

    always #4 clk = ~clk;

    // architectural result, 32-bit wrap
    function automatic reg_width_t golden(alu_op_t op, reg_width_t a, reg_width_t b);
        logic [63:0] prod;
        prod = {32'b0, a} * {32'b0, b};
        case (op)
            op_add:  golden = a + b;
            op_sub:  golden = a + ~b + 32'd1;
            op_and:  golden = a & b;
            op_or:   golden = a | b;
            op_xor:  golden = a ^ b;
            op_sll:  golden = a << b[4:0];
            op_mul:  golden = prod[31:0];
            default: golden = '0;
        endcase
    endfunction

    function automatic logic next_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    // reads the program and runs the register model in program order
    task automatic load_program();
        int          fd;
        int          got;
        int          tid;
        int          dep;
        string       line;
        logic [31:0] f [10];
        reg_width_t  arch [32];
        int          last_mul [32];
        reg_width_t  a;
        reg_width_t  b;
        reg_width_t  r;
        n_prog = 0;
        for (int t = 0; t <= n_tests; t++) exp_count[t] = 0;
        for (int k = 0; k < 32; k++) arch[k] = '0;
        for (int k = 0; k < 32; k++) last_mul[k] = -1;
        fd = $fopen("issue_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open issue_testdata.txt");
            aborted = 1'b1;
        end else begin
            while (!$feof(fd) && n_prog < max_prog) begin
                line = "";
                got = $fgets(line, fd);
                got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                tid = int'(f[0]);
                if (got == 10 && tid >= 1 && tid <= n_tests) begin
                    prog_test[n_prog]             = tid;
                    prog[n_prog].alu_op           = alu_op_t'(f[1][2:0]);
                    prog[n_prog].write_reg_need   = f[2][0];
                    prog[n_prog].write_reg_addr   = f[3][4:0];
                    prog[n_prog].num1_need        = f[4][0];
                    prog[n_prog].num1_addr        = f[5][4:0];
                    prog[n_prog].num1             = f[6];
                    prog[n_prog].num2_need        = f[7][0];
                    prog[n_prog].num2_addr        = f[8][4:0];
                    prog[n_prog].num2             = f[9];
                    a = f[4][0] ? arch[f[5][4:0]] : f[6];
                    b = f[7][0] ? arch[f[8][4:0]] : f[9];
                    r = golden(prog[n_prog].alu_op, a, b);
                    dep = -1;
                    if (f[4][0] && last_mul[f[5][4:0]] > dep) dep = last_mul[f[5][4:0]];
                    if (f[7][0] && last_mul[f[8][4:0]] > dep) dep = last_mul[f[8][4:0]];
                    if (f[2][0]) begin
                        exp_addr.push_back(f[3][4:0]);
                        exp_data.push_back(r);
                        exp_after.push_back(dep);
                        exp_count[tid]++;
                        if (f[3][4:0] != 5'd0) begin
                            arch[f[3][4:0]] = r; // r0 stays zero
                            last_mul[f[3][4:0]] = (prog[n_prog].alu_op == op_mul)
                                                ? exp_addr.size() - 1 : -1;
                        end
                    end
                    n_prog++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic idle_gap();
        int gap;
        gap = int'(next_bit());
        gap = 2 * gap + int'(next_bit());
        repeat (gap) @(negedge clk);
    endtask

    task automatic wait_ack(input logic level, output int cycles);
        cycles = 0;
        while (in_ack !== level && cycles < ack_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (in_ack !== level) begin
            $display("timeout: in_ack did not go to %0d within %0d cycles at %0t",
                     level, ack_limit, $time);
            aborted = 1'b1;
        end
    endtask

    task automatic send_instr(input iq_element_t ins, output int waited);
        int back;
        in_alu_op         = ins.alu_op;
        in_num1_need      = ins.num1_need;
        in_num1_addr      = ins.num1_addr;
        in_num1           = ins.num1;
        in_num2_need      = ins.num2_need;
        in_num2_addr      = ins.num2_addr;
        in_num2           = ins.num2;
        in_write_reg_need = ins.write_reg_need;
        in_write_reg_addr = ins.write_reg_addr;
        in_req            = 1'b1;
        wait_ack(1'b1, waited);
        in_req = 1'b0;
        if (!aborted) wait_ack(1'b0, back);
    endtask

    task automatic run_test(input int t);
        int err_before;
        int wb_before;
        int target;
        int sent;
        int waited;
        int max_wait;
        int cycles;
        err_before = errors + mon_errors;
        wb_before  = wb_seen;
        target     = wb_seen + exp_count[t];
        sent       = 0;
        max_wait   = 0;
        for (int i = 0; i < n_prog; i++) begin
            if (prog_test[i] == t && !aborted) begin
                if (t != burst_test && sent > 0) idle_gap();
                send_instr(prog[i], waited);
                sent++;
                if (waited > max_wait) max_wait = waited;
            end
        end
        cycles = 0;
        while (!aborted && wb_seen < target && cycles < drain_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!aborted && wb_seen < target) begin
            $display("timeout: test %0d saw only %0d of %0d writebacks",
                     t, wb_seen - wb_before, exp_count[t]);
            aborted = 1'b1;
        end
        if (!aborted && t == burst_test && max_wait < 2) begin
            $display("test %0d: in_ack never held off, the queue did not fill", t);
            errors++;
        end
        $display("test %0d: %0d instructions, %0d writebacks, %s", t, sent,
                 wb_seen - wb_before,
                 (errors + mon_errors == err_before && !aborted) ? "ok" : "with errors");
    endtask

    // writebacks compared in order, lane 0 first
    always @(negedge clk) begin
        cycle_no++;
        if (rst_n) begin
            for (int l = 0; l < 2; l++) begin
                if (wb_ena[l]) begin
                    if (wb_seen >= exp_addr.size()) begin
                        $display("unexpected writeback on lane %0d to r%0d at %0t",
                                 l, wb_addr[l], $time);
                        mon_errors++;
                    end else begin
                        if (wb_addr[l] != exp_addr[wb_seen]
                            || wb_data[l] != exp_data[wb_seen]) begin
                            $display("mismatch at %0t: lane %0d wrote r%0d = %h, expected r%0d = %h",
                                     $time, l, wb_addr[l], wb_data[l],
                                     exp_addr[wb_seen], exp_data[wb_seen]);
                            mon_errors++;
                        end
                        if (exp_after[wb_seen] >= 0
                            && cycle_no - wb_cycle[exp_after[wb_seen]] < min_mul_gap) begin
                            $display("r%0d written back %0d cycles after the mul it reads at %0t",
                                     wb_addr[l], cycle_no - wb_cycle[exp_after[wb_seen]],
                                     $time);
                            mon_errors++;
                        end
                    end
                    wb_cycle.push_back(cycle_no);
                    wb_seen++;
                end
            end
        end
    end

    initial begin
        clk               = 1'b0;
        rst_n             = 1'b1;
        in_req            = 1'b0;
        in_alu_op         = op_add;
        in_num1_need      = 1'b0;
        in_num1_addr      = '0;
        in_num1           = '0;
        in_num2_need      = 1'b0;
        in_num2_addr      = '0;
        in_num2           = '0;
        in_write_reg_need = 1'b0;
        in_write_reg_addr = '0;
        lfsr              = 16'd56566;
        errors            = 0;
        aborted           = 1'b0;
        load_program();
        #1 rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int t = 1; t <= n_tests; t++) begin
            if (!aborted) run_test(t);
        end
        repeat (10) @(negedge clk); // stray writebacks
        if (!aborted && wb_seen != exp_addr.size()) begin
            $display("writeback count %0d differs from the %0d writing instructions",
                     wb_seen, exp_addr.size());
            errors++;
        end
        $display("%0d tests, %0d writebacks, %0d errors", n_tests, wb_seen,
                 errors + mon_errors + int'(aborted));
        if (errors == 0 && mon_errors == 0 && !aborted && n_prog > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: issue_testdata.txt
// test op wr_need wr_addr n1_need n1_addr n1 n2_need n2_addr n2, all hex
// op codes: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 mul
1 0 1 01 0 00 00000005 0 00 00000007
1 3 1 02 0 00 000000f0 0 00 0000000f
1 0 1 03 1 00 00000000 0 00 00000011
1 5 1 04 0 00 00000003 0 00 00000004
2 6 1 08 1 02 00000000 1 01 00000000   // mul stalls the chain behind it
2 0 1 09 1 08 00000000 0 00 00000001
2 4 1 0a 1 09 00000000 1 03 00000000
2 0 1 0b 1 0a 00000000 1 09 00000000
2 1 1 0c 1 0b 00000000 1 09 00000000
3 6 1 0d 1 01 00000000 0 00 00000003
3 0 1 0e 1 0d 00000000 1 0d 00000000
3 6 1 0f 1 0e 00000000 1 0d 00000000
4 6 1 10 1 0d 00000000 1 0e 00000000
4 0 1 11 1 10 00000000 0 00 00000001
4 3 1 11 1 11 00000000 1 01 00000000   // reads and rewrites r17
5 0 1 16 0 00 00000003 0 00 00000000
5 6 1 16 1 16 00000000 0 00 00000003
5 6 1 16 1 16 00000000 0 00 00000003
5 6 1 16 1 16 00000000 0 00 00000003
5 6 1 16 1 16 00000000 0 00 00000003
5 6 1 16 1 16 00000000 0 00 00000003
5 6 1 16 1 16 00000000 0 00 00000003
5 6 1 16 1 16 00000000 0 00 00000003
5 6 1 16 1 16 00000000 0 00 00000003
5 6 1 16 1 16 00000000 0 00 00000003
5 6 1 16 1 16 00000000 0 00 00000003
5 6 1 16 1 16 00000000 0 00 00000003
5 6 1 16 1 16 00000000 0 00 00000003
5 6 1 16 1 16 00000000 0 00 00000003
6 0 1 00 0 00 00000055 0 00 00000000   // r0 write, later reads still zero
6 0 1 14 1 00 00000000 0 00 00000001
6 3 1 15 1 00 00000000 1 01 00000000

// File: src.f
issue_pkg.sv
issue_queue.sv
score_board.sv
regfile.sv
issue.sv
exec_pipe.sv
issue_top.sv
issue_chk.sv
tb_issue.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_issue -f src.f \
    && ./obj_dir/Vtb_issue | tee /dev/stderr | grep -q "^RESULT: PASS$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
